// File: hw/db_cfg_pkg.sv
// buffer sizes and slot types, imported by every block of the packet buffer
package db_cfg_pkg;

    // slot memory geometry
    localparam int SLOT_NUM   = 64;
    localparam int SLOT_AW    = 6;
    localparam int SLOT_WIDTH = 32;

    // one slot address
    typedef logic [SLOT_AW-1:0] slot_addr_t;

    // count of slots, has to reach SLOT_NUM itself
    typedef logic [SLOT_AW:0] slot_cnt_t;

    // payload of one flit
    typedef logic [SLOT_WIDTH-1:0] flit_data_t;

    // slot 0 is never handed out and marks the end of nothing
    localparam slot_addr_t NULL_SLOT = '0;

endpackage

// File: hw/db_if_pkg.sv
// payload structs and read opcode of the insert, read and response channels
package db_if_pkg;

    import db_cfg_pkg::*;

    // selects what a read request does with the chain it walks
    typedef enum logic {
        RD_GET    = 1'b0,
        RD_DELETE = 1'b1
    } read_op_e;

    // one flit on the insert channel
    // a flit after a last flit opens the next packet
    typedef struct packed {
        logic       last;
        flit_data_t data;
    } insert_flit_t;

    // one request on the read channel
    typedef struct packed {
        read_op_e   op;
        slot_addr_t count;
        slot_addr_t head;
    } read_req_t;

    // one flit on the response channel
    typedef struct packed {
        logic       start;
        logic       last;
        flit_data_t data;
    } resp_flit_t;

endpackage

// File: hw/db_sdp_ram.sv
// simple dual-port RAM with registered read, holds flit data or next pointers
`timescale 1ns/1ps

module db_sdp_ram
    import db_cfg_pkg::*;
#(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 64
) (
    input  logic              clk,

    // write port
    input  logic              i_we,
    input  slot_addr_t        i_waddr,
    input  logic [DATA_W-1:0] i_wdata,

    // read port, one cycle latency
    input  slot_addr_t        i_raddr,
    output logic [DATA_W-1:0] o_rdata
);

    logic [DATA_W-1:0] mem [DEPTH];

    // write side
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read side, old data on a same-address collision
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

// File: hw/db_free_list.sv
// FIFO of free slot addresses with its fill after reset and occupancy count
`timescale 1ns/1ps

module db_free_list
    import db_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // slot returned by a delete
    input  logic       i_push,
    input  slot_addr_t i_push_addr,

    // slot taken by an insert
    input  logic       i_pop,
    output slot_addr_t o_head,

    output logic       o_ready,
    output slot_cnt_t  o_count
);

    slot_addr_t mem [SLOT_NUM];

    slot_addr_t wr_ptr;
    slot_addr_t rd_ptr;
    slot_cnt_t  count;
    slot_cnt_t  init_cnt;

    logic       init_done;
    logic       init_push;
    logic       wr_en;
    slot_addr_t wr_data;

    // fill walks 0..SLOT_NUM-1 and skips the null slot
    assign init_done = (init_cnt == slot_cnt_t'(SLOT_NUM));
    assign init_push = !init_done && (init_cnt != '0);

    assign wr_en   = init_push | i_push;
    assign wr_data = init_push ? init_cnt[SLOT_AW-1:0] : i_push_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            if (!init_done) begin
                init_cnt <= init_cnt + slot_cnt_t'(1);
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + slot_addr_t'(1);
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + slot_addr_t'(1);
            end
            // push and pop together leave the count alone
            case ({wr_en, i_pop})
                2'b10:   count <= count + slot_cnt_t'(1);
                2'b01:   count <= count - slot_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign o_head  = mem[rd_ptr];
    assign o_ready = init_done && (count != '0);
    assign o_count = count;

endmodule

// File: hw/db_insert_ctrl.sv
// insert side, takes flits into free slots and links each packet's chain
`timescale 1ns/1ps

module db_insert_ctrl
    import db_cfg_pkg::*;
    import db_if_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // insert channel
    input  logic         i_ins_valid,
    input  insert_flit_t i_ins_flit,
    output logic         o_ins_ready,
    output slot_addr_t   o_ins_addr,

    // free list
    input  slot_addr_t   i_free_head,
    input  logic         i_free_ready,
    output logic         o_free_pop,

    // content table write port
    output logic         o_content_we,
    output slot_addr_t   o_content_waddr,
    output flit_data_t   o_content_wdata,

    // next table write port
    output logic         o_next_we,
    output slot_addr_t   o_next_waddr,
    output slot_addr_t   o_next_wdata
);

    typedef enum logic {
        ST_FIRST,
        ST_IN_PKT
    } ins_state_e;

    ins_state_e state;
    slot_addr_t prev_slot;
    logic       xfer;

    assign o_ins_ready = i_free_ready;
    assign xfer        = i_ins_valid && o_ins_ready;

    // slot of the flit being taken, zero when nothing can be taken
    assign o_ins_addr = o_ins_ready ? i_free_head : NULL_SLOT;
    assign o_free_pop = xfer;

    assign o_content_we    = xfer;
    assign o_content_waddr = i_free_head;
    assign o_content_wdata = i_ins_flit.data;

    // link the previous flit of the same packet to this one
    assign o_next_we    = xfer && (state == ST_IN_PKT);
    assign o_next_waddr = prev_slot;
    assign o_next_wdata = i_free_head;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_FIRST;
        end else if (xfer) begin
            state <= i_ins_flit.last ? ST_FIRST : ST_IN_PKT;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            prev_slot <= i_free_head;
        end
    end

endmodule

// File: hw/db_read_ctrl.sv
// read side, walks a stored chain for get or delete and frees slots on delete
`timescale 1ns/1ps

module db_read_ctrl
    import db_cfg_pkg::*;
    import db_if_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // read request channel
    input  logic       i_rd_valid,
    input  read_req_t  i_rd_req,
    output logic       o_rd_ready,

    // response channel
    output logic       o_resp_valid,
    output resp_flit_t o_resp_flit,
    input  logic       i_resp_ready,

    // shared read address of both tables
    output slot_addr_t o_raddr,
    input  flit_data_t i_content_rdata,
    input  slot_addr_t i_next_rdata,

    // slots returned by a delete
    output logic       o_free_push,
    output slot_addr_t o_free_push_addr
);

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } rd_state_e;

    rd_state_e  state;
    read_op_e   op;
    slot_addr_t remain;
    slot_addr_t total;
    slot_addr_t cur_addr;

    logic       accept;
    logic       take;
    logic       is_last;

    assign o_rd_ready   = (state == ST_IDLE);
    assign o_resp_valid = (state == ST_STREAM);

    assign accept  = i_rd_valid && o_rd_ready;
    assign take    = o_resp_valid && i_resp_ready;
    assign is_last = (remain == slot_addr_t'(1));

    // head on accept, follow the chain on take, otherwise re-read
    // the current slot so both table outputs hold
    always_comb begin
        if (accept) begin
            o_raddr = i_rd_req.head;
        end else if (take) begin
            o_raddr = i_next_rdata;
        end else begin
            o_raddr = cur_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            op       <= RD_GET;
            remain   <= '0;
            total    <= '0;
            cur_addr <= NULL_SLOT;
        end else begin
            // slot whose data sits on the table outputs next cycle
            cur_addr <= o_raddr;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state  <= ST_STREAM;
                        op     <= i_rd_req.op;
                        remain <= i_rd_req.count;
                        total  <= i_rd_req.count;
                    end
                end
                ST_STREAM: begin
                    if (take) begin
                        remain <= remain - slot_addr_t'(1);
                        if (is_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // response flit
    assign o_resp_flit.start = o_resp_valid && (remain == total);
    assign o_resp_flit.last  = o_resp_valid && is_last;
    assign o_resp_flit.data  = i_content_rdata;

    // a deleted slot goes back once its flit has left
    assign o_free_push      = take && (op == RD_DELETE);
    assign o_free_push_addr = cur_addr;

endmodule

// File: hw/db_top.sv
// packet buffer top, connects both controllers, the two tables and the free list
`timescale 1ns/1ps

module db_top
    import db_cfg_pkg::*;
    import db_if_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // insert channel
    input  logic         i_ins_valid,
    input  insert_flit_t i_ins_flit,
    output logic         o_ins_ready,
    output slot_addr_t   o_ins_addr,

    // read channel
    input  logic         i_rd_valid,
    input  read_req_t    i_rd_req,
    output logic         o_rd_ready,
    output logic         o_resp_valid,
    output resp_flit_t   o_resp_flit,
    input  logic         i_resp_ready,

    // free slots left
    output slot_cnt_t    o_free_slots
);

    // free list
    slot_addr_t free_head;
    logic       free_ready;
    logic       free_pop;
    logic       free_push;
    slot_addr_t free_push_addr;

    // table write side
    logic       content_we;
    slot_addr_t content_waddr;
    flit_data_t content_wdata;
    logic       next_we;
    slot_addr_t next_waddr;
    slot_addr_t next_wdata;

    // table read side, one address for both
    slot_addr_t raddr;
    flit_data_t content_rdata;
    slot_addr_t next_rdata;

    db_insert_ctrl u_insert_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_ins_valid     (i_ins_valid),
        .i_ins_flit      (i_ins_flit),
        .o_ins_ready     (o_ins_ready),
        .o_ins_addr      (o_ins_addr),
        .i_free_head     (free_head),
        .i_free_ready    (free_ready),
        .o_free_pop      (free_pop),
        .o_content_we    (content_we),
        .o_content_waddr (content_waddr),
        .o_content_wdata (content_wdata),
        .o_next_we       (next_we),
        .o_next_waddr    (next_waddr),
        .o_next_wdata    (next_wdata)
    );

    db_read_ctrl u_read_ctrl (
        .clk              (clk),
        .rst              (rst),
        .i_rd_valid       (i_rd_valid),
        .i_rd_req         (i_rd_req),
        .o_rd_ready       (o_rd_ready),
        .o_resp_valid     (o_resp_valid),
        .o_resp_flit      (o_resp_flit),
        .i_resp_ready     (i_resp_ready),
        .o_raddr          (raddr),
        .i_content_rdata  (content_rdata),
        .i_next_rdata     (next_rdata),
        .o_free_push      (free_push),
        .o_free_push_addr (free_push_addr)
    );

    db_free_list u_free_list (
        .clk         (clk),
        .rst         (rst),
        .i_push      (free_push),
        .i_push_addr (free_push_addr),
        .i_pop       (free_pop),
        .o_head      (free_head),
        .o_ready     (free_ready),
        .o_count     (o_free_slots)
    );

    // flit payload per slot
    db_sdp_ram #(
        .DATA_W (SLOT_WIDTH),
        .DEPTH  (SLOT_NUM)
    ) content_table (
        .clk     (clk),
        .i_we    (content_we),
        .i_waddr (content_waddr),
        .i_wdata (content_wdata),
        .i_raddr (raddr),
        .o_rdata (content_rdata)
    );

    // following slot of the same packet
    db_sdp_ram #(
        .DATA_W (SLOT_AW),
        .DEPTH  (SLOT_NUM)
    ) next_table (
        .clk     (clk),
        .i_we    (next_we),
        .i_waddr (next_waddr),
        .i_wdata (next_wdata),
        .i_raddr (raddr),
        .o_rdata (next_rdata)
    );

endmodule

// File: sim/db_assertions.sv
// concurrent checks on the packet buffer channels, bound into the top level
`timescale 1ns/1ps

module db_assertions
    import db_cfg_pkg::*;
    import db_if_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       i_ins_valid,
    input logic       o_ins_ready,
    input slot_addr_t o_ins_addr,
    input logic       o_resp_valid,
    input resp_flit_t o_resp_flit,
    input logic       i_resp_ready,
    input slot_cnt_t  o_free_slots
);

    // set once the free list has been filled after reset
    logic fill_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_done <= 1'b0;
        end else if (o_free_slots == slot_cnt_t'(SLOT_NUM - 1)) begin
            fill_done <= 1'b1;
        end
    end

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp_flit))
        else $error("response flit changed while stalled");

    fill_block: assert property (@(posedge clk) disable iff (rst)
        !fill_done && (o_free_slots < slot_cnt_t'(SLOT_NUM - 1)) |-> !o_ins_ready)
        else $error("insert ready raised before the free list fill ended");

    no_null_slot: assert property (@(posedge clk) disable iff (rst)
        i_ins_valid && o_ins_ready |-> o_ins_addr != NULL_SLOT)
        else $error("insert transfer got the null slot");

endmodule

bind db_top db_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .i_ins_valid  (i_ins_valid),
    .o_ins_ready  (o_ins_ready),
    .o_ins_addr   (o_ins_addr),
    .o_resp_valid (o_resp_valid),
    .o_resp_flit  (o_resp_flit),
    .i_resp_ready (i_resp_ready),
    .o_free_slots (o_free_slots)
);

// File: sim/db_tb.sv
// testbench for the packet buffer that checks random inserts, gets and deletes against a model
`timescale 1ns/1ps

module db_tb
    import db_cfg_pkg::*;
    import db_if_pkg::*;
();

    localparam int MAX_LEN  = 8;
    localparam int NUM_OPS  = 300;
    localparam int WAIT_MAX = 200;

    logic         clk;
    logic         rst;
    logic         i_ins_valid;
    insert_flit_t i_ins_flit;
    logic         o_ins_ready;
    slot_addr_t   o_ins_addr;
    logic         i_rd_valid;
    read_req_t    i_rd_req;
    logic         o_rd_ready;
    logic         o_resp_valid;
    resp_flit_t   o_resp_flit;
    logic         i_resp_ready;
    slot_cnt_t    o_free_slots;

    // model of live packets and slot ownership
    logic [15:0]  lfsr_state;
    logic         slot_used [SLOT_NUM];
    logic         pkt_live  [SLOT_NUM];
    int           pkt_len   [SLOT_NUM];
    slot_addr_t   pkt_addr  [SLOT_NUM][MAX_LEN];
    flit_data_t   pkt_data  [SLOT_NUM][MAX_LEN];
    int           used_cnt;
    int           live_cnt;
    string        test_name;

    // packet currently on the read channel
    read_op_e     rd_op;
    int           rd_len;
    slot_addr_t   rd_addr [MAX_LEN];
    flit_data_t   rd_data [MAX_LEN];

    db_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_ins_valid  (i_ins_valid),
        .i_ins_flit   (i_ins_flit),
        .o_ins_ready  (o_ins_ready),
        .o_ins_addr   (o_ins_addr),
        .i_rd_valid   (i_rd_valid),
        .i_rd_req     (i_rd_req),
        .o_rd_ready   (o_rd_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_flit  (o_resp_flit),
        .i_resp_ready (i_resp_ready),
        .o_free_slots (o_free_slots)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            fail_now($sformatf("Error in %s: %s expected 0x%0h actual 0x%0h",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_free_count();
        check_value("free slot count", 64'(SLOT_NUM - 1 - used_cnt), 64'(o_free_slots));
    endtask

    task automatic wait_fill();
        int cycles;
        cycles = 0;
        while (o_free_slots != slot_cnt_t'(SLOT_NUM - 1)) begin
            check_value("insert ready during fill", 64'(0), 64'(o_ins_ready));
            @(negedge clk);
            cycles++;
            if (cycles > SLOT_NUM + 5) begin
                fail_now("free list fill did not finish in time");
            end
        end
        check_value("insert ready after fill", 64'(1), 64'(o_ins_ready));
    endtask

    task automatic insert_packet(input int len);
        int         idx;
        int         waits;
        slot_addr_t addr;
        flit_data_t data;
        idx = 0;
        while (pkt_live[idx]) begin
            idx++;
        end
        @(negedge clk);
        for (int k = 0; k < len; k++) begin
            data = rand_bits(32);
            i_ins_valid = 1'b1;
            i_ins_flit.last = (k == len - 1);
            i_ins_flit.data = data;
            #1;
            waits = 0;
            while (!o_ins_ready) begin
                @(negedge clk);
                #1;
                waits++;
                if (waits > WAIT_MAX) begin
                    fail_now("insert channel never became ready");
                end
            end
            addr = o_ins_addr;
            if (addr == NULL_SLOT) begin
                fail_now("insert returned the null slot");
            end
            if (slot_used[addr]) begin
                fail_now($sformatf("insert returned slot %0d which is already live", addr));
            end
            slot_used[addr] = 1'b1;
            used_cnt++;
            pkt_addr[idx][k] = addr;
            pkt_data[idx][k] = data;
            // transfer happens on the rising edge in between
            @(negedge clk);
        end
        i_ins_valid = 1'b0;
        pkt_len[idx] = len;
        pkt_live[idx] = 1'b1;
        live_cnt++;
    endtask

    // a delete leaves the model table at once and its slots go free flit by flit
    task automatic choose_packet(input read_op_e op);
        int n;
        int idx;
        n = int'(rand_bits(6)) % live_cnt;
        idx = 0;
        while (!pkt_live[idx] || n > 0) begin
            if (pkt_live[idx]) begin
                n--;
            end
            idx++;
        end
        rd_op = op;
        rd_len = pkt_len[idx];
        for (int k = 0; k < rd_len; k++) begin
            rd_addr[k] = pkt_addr[idx][k];
            rd_data[k] = pkt_data[idx][k];
        end
        if (op == RD_DELETE) begin
            pkt_live[idx] = 1'b0;
            live_cnt--;
        end
    endtask

    task automatic read_packet(input logic stall);
        int taken;
        int waits;
        @(negedge clk);
        i_rd_valid = 1'b1;
        i_rd_req.op = rd_op;
        i_rd_req.count = slot_addr_t'(rd_len);
        i_rd_req.head = rd_addr[0];
        #1;
        waits = 0;
        while (!o_rd_ready) begin
            @(negedge clk);
            #1;
            waits++;
            if (waits > WAIT_MAX) begin
                fail_now("read channel never became ready");
            end
        end
        taken = 0;
        waits = 0;
        while (taken < rd_len) begin
            @(negedge clk);
            i_rd_valid = 1'b0;
            // roughly one stall in four
            i_resp_ready = stall ? (lfsr_bit() | lfsr_bit()) : 1'b1;
            #1;
            check_value("response valid", 64'(1), 64'(o_resp_valid));
            if (i_resp_ready) begin
                check_value("response data", 64'(rd_data[taken]), 64'(o_resp_flit.data));
                check_value("response start", 64'(taken == 0), 64'(o_resp_flit.start));
                check_value("response last", 64'(taken == rd_len - 1), 64'(o_resp_flit.last));
                if (rd_op == RD_DELETE) begin
                    slot_used[rd_addr[taken]] = 1'b0;
                    used_cnt--;
                end
                taken++;
                waits = 0;
            end else begin
                waits++;
                if (waits > WAIT_MAX) begin
                    fail_now("response stream stalled too long");
                end
            end
        end
        @(negedge clk);
        i_resp_ready = 1'b0;
        #1;
        check_value("read ready after last flit", 64'(1), 64'(o_rd_ready));
    endtask

    task automatic run_random_op();
        logic [1:0] kind;
        int         len;
        int         room;
        kind = 2'(rand_bits(2));
        len = int'(rand_bits(3)) + 1;
        room = SLOT_NUM - 1 - used_cnt;
        if (live_cnt == 0) begin
            kind = 2'd0;
        end
        if (kind == 2'd0 && len > room) begin
            kind = 2'd2;
        end
        case (kind)
            2'd0: insert_packet(len);
            2'd1: begin
                choose_packet(RD_GET);
                read_packet(1'b1);
            end
            2'd2: begin
                choose_packet(RD_DELETE);
                read_packet(1'b1);
            end
            default: begin
                choose_packet(read_op_e'(lfsr_bit()));
                if (len > room) begin
                    read_packet(1'b1);
                end else begin
                    fork
                        read_packet(1'b1);
                        insert_packet(len);
                    join
                end
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        i_ins_valid = 1'b0;
        i_ins_flit = '0;
        i_rd_valid = 1'b0;
        i_rd_req = '0;
        i_resp_ready = 1'b0;
        lfsr_state = 16'd88;
        used_cnt = 0;
        live_cnt = 0;
        for (int i = 0; i < SLOT_NUM; i++) begin
            slot_used[i] = 1'b0;
            pkt_live[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        test_name = "reset";
        check_value("insert ready", 64'(0), 64'(o_ins_ready));
        check_value("response valid", 64'(0), 64'(o_resp_valid));
        check_value("insert address", 64'(0), 64'(o_ins_addr));
        check_value("read ready", 64'(1), 64'(o_rd_ready));
        rst = 1'b0;

        test_name = "fill";
        wait_fill();
        check_free_count();

        test_name = "directed";
        for (int i = 0; i < 4; i++) begin
            insert_packet(int'(rand_bits(3)) + 1);
        end
        check_free_count();
        // get without back-pressure runs one flit per cycle
        choose_packet(RD_GET);
        read_packet(1'b0);
        check_free_count();
        choose_packet(RD_DELETE);
        read_packet(1'b0);
        check_free_count();

        test_name = "random";
        for (int op = 0; op < NUM_OPS; op++) begin
            run_random_op();
            check_free_count();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: files.f
hw/db_cfg_pkg.sv
hw/db_if_pkg.sv
hw/db_sdp_ram.sv
hw/db_free_list.sv
hw/db_insert_ctrl.sv
hw/db_read_ctrl.sv
hw/db_top.sv
sim/db_assertions.sv
sim/db_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module db_tb -o db_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/db_tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
